//--- src.f
conv_pkg.sv
pe_multiplier.sv
pe_mac_datapath.sv
tap_counter.sv
pe_ctrl.sv
conv_pe_top.sv
tb_conv_pe.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_conv_pe -f src.f -o sim_conv_pe
./obj_dir/sim_conv_pe > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished clean"

//--- tb_conv_pe.sv
`timescale 1ns/1ps

module tb_conv_pe;

    localparam int KS = conv_pkg::KERNEL_SIZE;
    localparam time CLK_PERIOD = 100ns;
    localparam time DRIVE_DELAY = 5ns;
    localparam logic [31:0] SEED = 32'h6596;
    localparam int NUM_RANDOM = 50;
    // Single, random, extreme, two back-pressure, one after reset
    localparam int NUM_WINDOWS = NUM_RANDOM + 5;
    localparam int WATCHDOG_CYCLES = NUM_WINDOWS * 40 + 200;
    // Cycles allowed for any one handshake phase
    localparam int HS_TIMEOUT = 20;

    logic                                   clk = 1'b0;
    logic                                   rstn;
    logic                                   in_req;
    logic signed [conv_pkg::DATA_WIDTH-1:0] in_ifmap;
    logic signed [conv_pkg::DATA_WIDTH-1:0] in_fltr;
    logic        [conv_pkg::ACC_WIDTH-1:0]  in_psum;
    logic                                   in_ack;
    logic                                   out_ack;
    logic                                   out_req;
    logic        [conv_pkg::ACC_WIDTH-1:0]  out_psum;

    // Operands of the window being sent
    logic signed [conv_pkg::DATA_WIDTH-1:0] win_ifmap [KS];
    logic signed [conv_pkg::DATA_WIDTH-1:0] win_fltr [KS];
    logic        [31:0]                     win_psum;
    logic        [31:0]                     lfsr_state;
    int err_cnt;
    int check_cnt;
    int cycle_cnt = 0;
    // Edge of the latest capture and of the latest out_req rise
    int capture_cycle;
    int out_req_cycle;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    conv_pe_top dut (
        .clk      (clk),
        .rstn     (rstn),
        .in_req   (in_req),
        .in_ifmap (in_ifmap),
        .in_fltr  (in_fltr),
        .in_psum  (in_psum),
        .in_ack   (in_ack),
        .out_ack  (out_ack),
        .out_req  (out_req),
        .out_psum (out_psum)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        err_cnt++;
    endtask

    task automatic protocol_error(input string what);
        $display("Protocol error: %s", what);
        err_cnt++;
    endtask

    // Fibonacci taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic void fill_random();
        logic [31:0] r;
        for (int i = 0; i < KS; i++) begin
            r = take_bits(16);
            win_ifmap[i] = r[15:0];
            r = take_bits(16);
            win_fltr[i] = r[15:0];
        end
        win_psum = take_bits(32);
    endfunction

    // Reference: psum plus signed products, mod 2^32
    function automatic logic [31:0] window_sum();
        logic [31:0] acc;
        logic [31:0] prod;
        acc = win_psum;
        for (int i = 0; i < KS; i++) begin
            prod = {{16{win_ifmap[i][15]}}, win_ifmap[i]} *
                   {{16{win_fltr[i][15]}}, win_fltr[i]};
            acc = acc + prod;
        end
        return acc;
    endfunction

    task automatic raise_tap(input int idx);
        in_ifmap = win_ifmap[idx];
        in_fltr  = win_fltr[idx];
        // Later taps carry junk psum that must be ignored
        in_psum  = (idx == 0) ? win_psum : ~win_psum;
        in_req   = 1'b1;
    endtask

    // Wait for ack, release req, wait for ack to fall
    task automatic finish_tap(input string name);
        int waited;
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (!in_ack && waited < HS_TIMEOUT);
        in_req = 1'b0;
        if (!in_ack) begin
            protocol_error($sformatf("%s: tap never got in_ack", name));
            return;
        end
        capture_cycle = cycle_cnt;
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (in_ack && waited < HS_TIMEOUT);
        if (in_ack) begin
            protocol_error($sformatf("%s: in_ack stuck high after req fell", name));
        end
    endtask

    task automatic send_tap(input string name, input int idx);
        raise_tap(idx);
        finish_tap(name);
    endtask

    // Hold off out_ack for hold cycles, then complete the output handshake
    task automatic recv_result(input string name, input int hold, output logic [31:0] value);
        int waited;
        waited = 0;
        value = 'x;
        while (!out_req && waited < HS_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!out_req) begin
            protocol_error($sformatf("%s: out_req never rose", name));
            return;
        end
        out_req_cycle = cycle_cnt;
        value = out_psum;
        repeat (hold) begin
            next_cycle();
            check_cnt++;
            if (!out_req || out_psum !== value) begin
                protocol_error($sformatf("%s: result changed while out_ack held off", name));
            end
            if (in_ack) begin
                protocol_error($sformatf("%s: in_ack rose while a result was pending", name));
            end
        end
        out_ack = 1'b1;
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (out_req && waited < HS_TIMEOUT);
        if (out_req) begin
            protocol_error($sformatf("%s: out_req stayed high after out_ack", name));
        end
        out_ack = 1'b0;
    endtask

    task automatic run_window(input string name, input int hold);
        logic [31:0] exp;
        logic [31:0] got;
        exp = window_sum();
        for (int i = 0; i < KS; i++) begin
            send_tap(name, i);
        end
        recv_result(name, hold, got);
        check_cnt++;
        if (got !== exp) begin
            value_error(name, exp, got);
        end
    endtask

    // Host lets go of req before reset is released
    task automatic apply_reset();
        rstn = 1'b0;
        repeat (10) next_cycle();
        check_cnt++;
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
            protocol_error("in_ack or out_req not low during reset");
        end
        in_req = 1'b0;
        rstn = 1'b1;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_single();
        win_ifmap = '{16'sd1, 16'sd2, 16'sd3};
        win_fltr  = '{16'sd4, 16'sd5, 16'sd6};
        win_psum  = 32'd100;
        run_window("single", 0);
        // Two multiply stages, one add, one result load
        check_cnt++;
        if (out_req_cycle - capture_cycle != 4) begin
            value_error("single latency", 32'd4, 32'(out_req_cycle - capture_cycle));
        end
    endtask

    task automatic test_random();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            fill_random();
            run_window($sformatf("random %0d", n), int'(take_bits(2)));
        end
    endtask

    task automatic test_extreme();
        win_ifmap = '{-16'sd32768, -16'sd32768, -16'sd32768};
        win_fltr  = '{-16'sd32768, -16'sd32768, -16'sd32768};
        win_psum  = 32'h7fff_fff0;
        run_window("extreme", 0);
    endtask

    task automatic test_backpressure();
        logic [31:0] exp;
        logic [31:0] got;
        fill_random();
        exp = window_sum();
        for (int i = 0; i < KS; i++) begin
            send_tap("backpressure", i);
        end
        // Next window's first tap waits behind the pending result
        fill_random();
        raise_tap(0);
        recv_result("backpressure", 20, got);
        check_cnt++;
        if (got !== exp) begin
            value_error("backpressure", exp, got);
        end
        finish_tap("backpressure held tap");
        for (int i = 1; i < KS; i++) begin
            send_tap("backpressure next", i);
        end
        recv_result("backpressure next", 0, got);
        check_cnt++;
        if (got !== window_sum()) begin
            value_error("backpressure next", window_sum(), got);
        end
    endtask

    task automatic test_reset();
        int waited;
        fill_random();
        send_tap("abandoned", 0);
        // Second tap still holds its ack when reset hits
        raise_tap(1);
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (!in_ack && waited < HS_TIMEOUT);
        if (!in_ack) begin
            protocol_error("abandoned: second tap never got in_ack");
        end
        apply_reset();
        fill_random();
        run_window("after reset", 0);
    endtask

    initial begin
        rstn       = 1'b0;
        in_req     = 1'b0;
        in_ifmap   = '0;
        in_fltr    = '0;
        in_psum    = '0;
        out_ack    = 1'b0;
        err_cnt    = 0;
        check_cnt  = 0;
        lfsr_state = SEED;
        apply_reset();
        test_single();
        test_random();
        test_extreme();
        test_backpressure();
        test_reset();
        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the window count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired in state %s, %0d errors",
                 dut.u_ctrl.state.name(), err_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- conv_pe_top.sv
`timescale 1ns/1ps

module conv_pe_top (
    input  logic                                   clk,
    input  logic                                   rstn,
    // Input handshake
    input  logic                                   in_req,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] in_ifmap,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] in_fltr,
    input  logic        [conv_pkg::ACC_WIDTH-1:0]  in_psum,
    output logic                                   in_ack,
    // Output handshake
    input  logic                                   out_ack,
    output logic                                   out_req,
    output logic        [conv_pkg::ACC_WIDTH-1:0]  out_psum
);

    // Controller to datapath
    logic cap_en;
    logic first_tap;
    logic result_load;
    logic pipe_busy;
    // Controller to counter
    logic tap_inc;
    logic tap_clear;
    logic last_tap;

    pe_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .in_req      (in_req),
        .out_ack     (out_ack),
        .last_tap    (last_tap),
        .pipe_busy   (pipe_busy),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .cap_en      (cap_en),
        .first_tap   (first_tap),
        .result_load (result_load),
        .tap_inc     (tap_inc),
        .tap_clear   (tap_clear)
    );

    tap_counter u_tap_cnt (
        .clk       (clk),
        .rstn      (rstn),
        .tap_inc   (tap_inc),
        .tap_clear (tap_clear),
        .last_tap  (last_tap)
    );

    pe_mac_datapath u_datapath (
        .clk         (clk),
        .rstn        (rstn),
        .in_ifmap    (in_ifmap),
        .in_fltr     (in_fltr),
        .in_psum     (in_psum),
        .cap_en      (cap_en),
        .first_tap   (first_tap),
        .result_load (result_load),
        .pipe_busy   (pipe_busy),
        .out_psum    (out_psum)
    );

endmodule

//--- pe_ctrl.sv
`timescale 1ns/1ps

module pe_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic in_req,
    input  logic out_ack,
    input  logic last_tap,
    input  logic pipe_busy,
    output logic in_ack,
    output logic out_req,
    output logic cap_en,
    output logic first_tap,
    output logic result_load,
    output logic tap_inc,
    output logic tap_clear
);

    conv_pkg::ctrl_state_t state;
    conv_pkg::ctrl_state_t state_nxt;
    // Set when the tap being acked closed the window
    logic closing_tap;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= conv_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Counter sits on the last index for both of the final two taps
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            closing_tap <= 1'b0;
        end else if (cap_en) begin
            closing_tap <= last_tap;
        end
    end

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            // First tap of a window
            conv_pkg::ST_IDLE: begin
                if (in_req) begin
                    state_nxt = conv_pkg::ST_TAP_ACK;
                end
            end
            // Ack up, wait for host to release
            conv_pkg::ST_TAP_ACK: begin
                if (!in_req) begin
                    // Tap just acked was the closing one
                    if (closing_tap) begin
                        state_nxt = conv_pkg::ST_DRAIN;
                    end else begin
                        state_nxt = conv_pkg::ST_TAP_WAIT;
                    end
                end
            end
            conv_pkg::ST_TAP_WAIT: begin
                if (in_req) begin
                    state_nxt = conv_pkg::ST_TAP_ACK;
                end
            end
            // Products still moving through mult and add
            conv_pkg::ST_DRAIN: begin
                if (!pipe_busy) begin
                    state_nxt = conv_pkg::ST_OUT_REQ;
                end
            end
            // Result offered, inputs held off
            conv_pkg::ST_OUT_REQ: begin
                if (out_ack) begin
                    state_nxt = conv_pkg::ST_OUT_RELEASE;
                end
            end
            conv_pkg::ST_OUT_RELEASE: begin
                if (!out_ack) begin
                    state_nxt = conv_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = conv_pkg::ST_IDLE;
            end
        endcase
    end

    ////////////////////
    // Outputs
    ////////////////////

    // Handshake lines decoded straight from state
    assign in_ack  = (state == conv_pkg::ST_TAP_ACK);
    assign out_req = (state == conv_pkg::ST_OUT_REQ);

    // Accept only while ack is low and no result pending
    assign cap_en = in_req &&
                    ((state == conv_pkg::ST_IDLE) || (state == conv_pkg::ST_TAP_WAIT));
    assign first_tap = cap_en && (state == conv_pkg::ST_IDLE);
    // Closing tap leaves the counter on its last index
    assign tap_inc = cap_en && !last_tap;

    // One cycle pulse, accumulator settled
    assign result_load = (state == conv_pkg::ST_DRAIN) && !pipe_busy;
    // Output handshake done
    assign tap_clear = (state == conv_pkg::ST_OUT_RELEASE) && !out_ack;

endmodule

//--- tap_counter.sv
`timescale 1ns/1ps

module tap_counter (
    input  logic clk,
    input  logic rstn,
    input  logic tap_inc,
    input  logic tap_clear,
    output logic last_tap
);

    // Taps accepted so far in this window
    logic [conv_pkg::TAP_CNT_WIDTH-1:0] tap_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_cnt <= '0;
        end else if (tap_clear) begin
            tap_cnt <= '0;
        // Holds at the last index until cleared
        end else if (tap_inc && (tap_cnt != conv_pkg::LAST_TAP_IDX)) begin
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    // Next accepted transfer closes the window
    assign last_tap = (tap_cnt == conv_pkg::LAST_TAP_IDX);

endmodule

//--- pe_mac_datapath.sv
`timescale 1ns/1ps

module pe_mac_datapath (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] in_ifmap,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] in_fltr,
    input  logic        [conv_pkg::ACC_WIDTH-1:0]  in_psum,
    input  logic                                   cap_en,
    input  logic                                   first_tap,
    input  logic                                   result_load,
    output logic                                   pipe_busy,
    output logic        [conv_pkg::ACC_WIDTH-1:0]  out_psum
);

    // Enough room for every product the multiplier can hold
    localparam int unsigned FLIGHT_WIDTH = $clog2(conv_pkg::MULT_LATENCY + 1);

    logic signed [conv_pkg::DATA_WIDTH-1:0] cap_ifmap;
    logic signed [conv_pkg::DATA_WIDTH-1:0] cap_fltr;
    logic                                   cap_valid;
    logic signed [conv_pkg::ACC_WIDTH-1:0]  product;
    logic                                   prod_valid;
    logic        [conv_pkg::ACC_WIDTH-1:0]  acc;
    logic        [FLIGHT_WIDTH-1:0]         in_flight;

    ////////////////////
    // Operand capture
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= cap_en;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_en) begin
            cap_ifmap <= in_ifmap;
            cap_fltr  <= in_fltr;
        end
    end

    pe_multiplier u_mult (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (cap_valid),
        .a         (cap_ifmap),
        .b         (cap_fltr),
        .product   (product),
        .out_valid (prod_valid)
    );

    // Products inside the multiplier, up on entry, down when added
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_flight <= '0;
        end else if (cap_valid && !prod_valid) begin
            in_flight <= in_flight + 1'b1;
        end else if (!cap_valid && prod_valid) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    assign pipe_busy = cap_valid || (in_flight != '0);

    ////////////////////
    // Accumulate
    ////////////////////

    // Seeded by the incoming psum, wraps at 32 bits
    always_ff @(posedge clk) begin
        if (cap_en && first_tap) begin
            acc <= in_psum;
        end else if (prod_valid) begin
            acc <= acc + $unsigned(product);
        end
        // Result holds until the next window
        if (result_load) begin
            out_psum <= acc;
        end
    end

endmodule

//--- pe_multiplier.sv
`timescale 1ns/1ps

module pe_multiplier (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   in_valid,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] a,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] b,
    output logic signed [conv_pkg::ACC_WIDTH-1:0]  product,
    output logic                                   out_valid
);

    // Stage 1 operand registers
    logic signed [conv_pkg::DATA_WIDTH-1:0] a_q;
    logic signed [conv_pkg::DATA_WIDTH-1:0] b_q;
    logic                                   valid_q;

    // Valid bits walk with the data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    // Payload stages, no reset needed
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
        // Stage 2, signed multiply sized to the full product
        product <= a_q * b_q;
    end

endmodule

//--- conv_pkg.sv
package conv_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////

    // ifmap and filter operands
    localparam int unsigned DATA_WIDTH = 16;
    // Product, partial sum and accumulator
    localparam int unsigned ACC_WIDTH = 32;

    ////////////////////
    // Window and pipe
    ////////////////////

    localparam int unsigned KERNEL_SIZE = 3;
    localparam int unsigned TAP_CNT_WIDTH = 2;
    // Index of the tap that closes a window
    localparam logic [TAP_CNT_WIDTH-1:0] LAST_TAP_IDX = TAP_CNT_WIDTH'(KERNEL_SIZE - 1);
    // Multiplier register stages
    localparam int unsigned MULT_LATENCY = 2;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_TAP_ACK     = 3'd1,
        ST_TAP_WAIT    = 3'd2,
        ST_DRAIN       = 3'd3,
        ST_OUT_REQ     = 3'd4,
        ST_OUT_RELEASE = 3'd5
    } ctrl_state_t;

endpackage
